// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ldst_unit -f sim.f -o tb_ldst_unit
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_ldst_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: sim.f
src/isa_pkg.sv
src/uarch_pkg.sv
src/ldst_pop.sv
src/ldst_control.sv
src/reg_bank.sv
src/data_mem.sv
src/ldst_unit.sv
tb/tb_ldst_unit.sv

// File: src/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem import isa_pkg::*, uarch_pkg::*;
(
	input  logic clk,
	input  logic rst_n,

	input  logic start,
	input  logic write,
	input  ptr   addr,
	input  word  data_wr,
	output logic ready,
	output word  data_rd,

	input  logic dbg_we,
	input  ptr   dbg_addr,
	input  word  dbg_wdata,
	output word  dbg_rdata
);

	word mem [MEM_WORDS];

	logic                    busy;
	logic [MEM_CNT_BITS-1:0] cnt;
	logic                    write_q;
	logic [MEM_IDX_BITS-1:0] idx_q;
	word                     data_q;

	assign ready = busy && cnt == '0;
	assign data_rd = mem[idx_q];
	assign dbg_rdata = mem[dbg_addr[MEM_IDX_BITS-1:0]];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (start) begin
			busy <= 1'b1;
			cnt <= MEM_CNT_BITS'(MEM_LATENCY - 1);
		end else if (ready) begin
			busy <= 1'b0;
		end else if (busy) begin
			cnt <= cnt - MEM_CNT_BITS'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			write_q <= write;
			idx_q <= addr[MEM_IDX_BITS-1:0];
			data_q <= data_wr;
		end
	end

	always_ff @(posedge clk) begin
		if (dbg_we)
			mem[dbg_addr[MEM_IDX_BITS-1:0]] <= dbg_wdata;
		if (ready && write_q)
			mem[idx_q] <= data_q; // store lands with ready.
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy || ready);

endmodule

`default_nettype wire

// File: src/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// --------------------
	// architectural sizes
	// --------------------
	localparam int NUM_REGS = 16;

	typedef logic [31:0] word;
	typedef logic [29:0] ptr; // byte address bits 31..2.
	typedef logic [3:0] reg_num;
	typedef logic [NUM_REGS-1:0] reg_list; // bit n selects register n.

	// --------------------
	// transfer opcode
	// --------------------
	typedef enum logic {
		op_load  = 1'b0,
		op_store = 1'b1
	} ldst_op;

endpackage

`default_nettype wire

// File: src/ldst_control.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_control import isa_pkg::*, uarch_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,

	input  logic    cmd_req,
	input  logic    cmd_pre,
	input  logic    cmd_increment,
	input  logic    cmd_writeback,
	input  ldst_op  cmd_op,
	input  reg_num  cmd_base,
	input  reg_list cmd_regs,
	output logic    cmd_ack,

	output reg_num  rf_raddr,
	input  word     rf_rdata,
	output logic    rf_we,
	output reg_num  rf_waddr,
	output word     rf_wdata,

	output logic    mem_start,
	output logic    mem_write,
	output ptr      mem_addr,
	output word     mem_data_wr,
	input  logic    mem_ready,
	input  word     mem_data_rd
);

	function automatic logic [4:0] count_regs(input reg_list regs);
		logic [4:0] n;
		n = '0;
		for (int i = 0; i < NUM_REGS; i++)
			n = n + 5'(regs[i]);
		return n;
	endfunction

	ctrl_state state;
	logic      txn_open;

	ldst_op    op_q;
	logic      inc_q, wb_q;
	reg_num    base_q, cur_reg;
	reg_list   regs_q, next_regs;
	ptr        cur_addr, base_ptr, first_addr, step_addr;
	word       wb_value, list_bytes;

	logic      pop_valid;
	reg_num    popped, pop_upper, pop_lower;
	reg_list   next_upper, next_lower;
	logic      accept, issue;

	ldst_pop pop (
		.regs(regs_q),
		.valid(pop_valid),
		.next_upper(next_upper),
		.next_lower(next_lower),
		.pop_upper(pop_upper),
		.pop_lower(pop_lower)
	);

	// decrement walks the list from the top.
	assign popped = inc_q ? pop_lower : pop_upper;
	assign next_regs = inc_q ? next_lower : next_upper;

	assign accept = state == st_idle && cmd_req;
	assign issue = state == st_transfer && pop_valid;

	assign base_ptr = rf_rdata[31:2];
	assign first_addr = !cmd_pre ? base_ptr :
		cmd_increment ? base_ptr + ptr'(1) : base_ptr - ptr'(1);
	assign step_addr = inc_q ? cur_addr + ptr'(1) : cur_addr - ptr'(1);
	assign list_bytes = word'(count_regs(cmd_regs)) << 2;

	// --------------------
	// register bank side
	// --------------------
	assign rf_raddr = state == st_idle ? cmd_base : popped; // base read while idle.
	assign rf_we = (state == st_wait && mem_ready && op_q == op_load) ||
		state == st_writeback;
	assign rf_waddr = state == st_writeback ? base_q : cur_reg;
	assign rf_wdata = state == st_writeback ? wb_value : mem_data_rd;

	// --------------------
	// memory side
	// --------------------
	assign mem_start = issue;
	assign mem_write = issue && op_q == op_store;
	assign mem_addr = cur_addr;
	assign mem_data_wr = rf_rdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			cmd_ack <= 1'b0;
			txn_open <= 1'b0;
		end else begin
			if (mem_start)
				txn_open <= 1'b1;
			else if (mem_ready)
				txn_open <= 1'b0;

			unique case (state)
				st_idle:
					if (cmd_req)
						state <= st_transfer;
				st_transfer:
					if (pop_valid)
						state <= st_wait;
					else if (wb_q)
						state <= st_writeback;
					else
						state <= st_done;
				st_wait:
					if (mem_ready)
						state <= st_transfer;
				st_writeback:
					state <= st_done;
				st_done:
					if (cmd_req) begin
						cmd_ack <= 1'b1; // hold until requester lets go.
					end else begin
						cmd_ack <= 1'b0;
						state <= st_idle;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op_q <= cmd_op;
			inc_q <= cmd_increment;
			wb_q <= cmd_writeback && |cmd_regs; // empty list skips writeback.
			base_q <= cmd_base;
			regs_q <= cmd_regs;
			cur_addr <= first_addr;
			wb_value <= cmd_increment ? rf_rdata + list_bytes : rf_rdata - list_bytes;
		end else if (issue) begin
			regs_q <= next_regs;
			cur_reg <= popped;
			cur_addr <= step_addr;
		end
	end

	// --------------------
	// assertions
	// --------------------
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		mem_start |-> !txn_open);

	a_ready_latency: assert property (@(posedge clk) disable iff (!rst_n)
		mem_start |-> ##MEM_LATENCY mem_ready);

	a_ack_in_done: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cmd_ack) |-> state == st_done);

endmodule

`default_nettype wire

// File: src/ldst_pop.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_pop import isa_pkg::*;
(
	input  reg_list regs,
	output logic    valid,
	output reg_list next_upper,
	output reg_list next_lower,
	output reg_num  pop_upper,
	output reg_num  pop_lower
);

	assign valid = |regs;

	// lowest set bit, scanning down so the last hit wins.
	always_comb begin
		pop_lower = '0;
		for (int i = NUM_REGS - 1; i >= 0; i--) begin
			if (regs[i])
				pop_lower = reg_num'(i);
		end
	end

	// highest set bit, scanning up.
	always_comb begin
		pop_upper = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			if (regs[i])
				pop_upper = reg_num'(i);
		end
	end

	assign next_lower = regs & (regs - reg_list'(1)); // drops lowest one.
	assign next_upper = regs & ~(reg_list'(1) << pop_upper);

endmodule

`default_nettype wire

// File: src/ldst_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_unit import isa_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,

	input  logic    cmd_req,
	input  ldst_op  cmd_op,
	input  reg_num  cmd_base,
	input  reg_list cmd_regs,
	input  logic    cmd_pre,
	input  logic    cmd_increment,
	input  logic    cmd_writeback,
	output logic    cmd_ack,

	input  logic    dbg_reg_we,
	input  reg_num  dbg_reg,
	input  word     dbg_reg_wdata,
	output word     dbg_reg_rdata,

	input  logic    dbg_mem_we,
	input  ptr      dbg_mem_addr,
	input  word     dbg_mem_wdata,
	output word     dbg_mem_rdata
);

	reg_num rf_raddr, rf_waddr;
	word    rf_rdata, rf_wdata;
	logic   rf_we;

	logic   mem_start, mem_write, mem_ready;
	ptr     mem_addr;
	word    mem_data_wr, mem_data_rd;

	ldst_control ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_req(cmd_req),
		.cmd_pre(cmd_pre),
		.cmd_increment(cmd_increment),
		.cmd_writeback(cmd_writeback),
		.cmd_op(cmd_op),
		.cmd_base(cmd_base),
		.cmd_regs(cmd_regs),
		.cmd_ack(cmd_ack),
		.rf_raddr(rf_raddr),
		.rf_rdata(rf_rdata),
		.rf_we(rf_we),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata),
		.mem_start(mem_start),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_data_wr(mem_data_wr),
		.mem_ready(mem_ready),
		.mem_data_rd(mem_data_rd)
	);

	reg_bank regs (
		.clk(clk),
		.rst_n(rst_n),
		.raddr(rf_raddr),
		.rdata(rf_rdata),
		.we(rf_we),
		.waddr(rf_waddr),
		.wdata(rf_wdata),
		.dbg_we(dbg_reg_we),
		.dbg_reg(dbg_reg),
		.dbg_wdata(dbg_reg_wdata),
		.dbg_rdata(dbg_reg_rdata)
	);

	data_mem mem (
		.clk(clk),
		.rst_n(rst_n),
		.start(mem_start),
		.write(mem_write),
		.addr(mem_addr),
		.data_wr(mem_data_wr),
		.ready(mem_ready),
		.data_rd(mem_data_rd),
		.dbg_we(dbg_mem_we),
		.dbg_addr(dbg_mem_addr),
		.dbg_wdata(dbg_mem_wdata),
		.dbg_rdata(dbg_mem_rdata)
	);

endmodule

`default_nettype wire

// File: src/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank import isa_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,

	input  reg_num raddr,
	output word    rdata,

	input  logic   we,
	input  reg_num waddr,
	input  word    wdata,

	input  logic   dbg_we,
	input  reg_num dbg_reg,
	input  word    dbg_wdata,
	output word    dbg_rdata
);

	word regs [NUM_REGS];

	assign rdata = regs[raddr];
	assign dbg_rdata = regs[dbg_reg];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else begin
			if (dbg_we)
				regs[dbg_reg] <= dbg_wdata;
			if (we)
				regs[waddr] <= wdata; // engine wins a collision.
		end
	end

endmodule

`default_nettype wire

// File: src/uarch_pkg.sv
`default_nettype none

package uarch_pkg;

	// --------------------
	// sequencer
	// --------------------
	typedef enum logic [2:0] {
		st_idle      = 3'd0,
		st_transfer  = 3'd1,
		st_wait      = 3'd2,
		st_writeback = 3'd3,
		st_done      = 3'd4
	} ctrl_state;

	// --------------------
	// word memory
	// --------------------
	localparam int MEM_WORDS = 256;
	localparam int MEM_IDX_BITS = $clog2(MEM_WORDS); // low bits of ptr used as index.
	localparam int MEM_LATENCY = 2; // start to ready, in cycles.
	localparam int MEM_CNT_BITS = $clog2(MEM_LATENCY + 1);

endpackage

`default_nettype wire

// File: tb/ldst_cases.txt
// base_val op base_reg regs pre inc wb seed exp_base exp_count, all hex
// op 0 load, 1 store; seed 0 keeps the registers left by the previous case
00000100 1 d 00ff 0 1 1 00000001 00000120 8
00000200 1 2 8421 1 1 0 00000002 00000200 4
00000040 1 4 0ff0 1 1 1 00000003 00000060 8
00000120 0 d 00ff 1 0 1 00000004 00000100 8
000003fc 0 1 00f0 0 0 0 00000005 000003fc 4
00000080 0 5 0060 1 0 1 00000006 00000078 2
00000010 0 3 000f 0 1 1 00000007 00000020 4
// empty lists
00000200 1 0 0000 1 1 1 00000008 00000200 0
00000300 0 f 0000 0 0 1 00000009 00000300 0
// full list, then commands on carried state
00000400 1 e ffff 1 0 1 0000000a 000003c0 10
000003c0 1 e ffff 1 0 1 00000000 00000380 10
00000380 0 e 7fff 0 1 1 00000000 000003bc f
// address wrap at zero
00000000 1 6 0003 0 1 0 0000000b 00000000 2
00000000 0 6 0300 1 0 1 0000000c fffffff8 2
00000250 1 9 5000 0 0 1 0000000d 00000248 2
00000150 0 a 0180 1 1 0 0000000e 00000150 2
000001f0 1 b 0800 1 1 1 0000000f 000001f4 1
000002a0 0 c 1000 0 0 1 00000010 0000029c 1
0000029c 0 c 1000 0 0 1 00000000 00000298 1
000000fc 1 7 aaaa 0 1 0 00000011 000000fc 8

// File: tb/tb_ldst_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ldst_unit import isa_pkg::*, uarch_pkg::*;
();

	localparam int MAX_CASES = 32;
	localparam int FIELDS = 10;
	localparam int CASE_CYCLES = 17 * (MEM_LATENCY + 1) + 10;

	logic    clk;
	logic    rst_n;
	logic    cmd_req, cmd_pre, cmd_increment, cmd_writeback;
	ldst_op  cmd_op;
	reg_num  cmd_base;
	reg_list cmd_regs;
	logic    cmd_ack;
	logic    dbg_reg_we, dbg_mem_we;
	reg_num  dbg_reg;
	ptr      dbg_mem_addr;
	word     dbg_reg_wdata, dbg_reg_rdata, dbg_mem_wdata, dbg_mem_rdata;

	word case_data [MAX_CASES * FIELDS];
	word exp_reg [NUM_REGS];
	word init_reg [NUM_REGS];
	word exp_mem [MEM_WORDS];
	int  num_cases, limit;
	int  busy_cycles = 0;
	int  txn_count = 0;
	int  word_errors = 0;
	int  list_errors = 0;
	int  proto_errors = 0;

	ldst_unit uut (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_req(cmd_req),
		.cmd_op(cmd_op),
		.cmd_base(cmd_base),
		.cmd_regs(cmd_regs),
		.cmd_pre(cmd_pre),
		.cmd_increment(cmd_increment),
		.cmd_writeback(cmd_writeback),
		.cmd_ack(cmd_ack),
		.dbg_reg_we(dbg_reg_we),
		.dbg_reg(dbg_reg),
		.dbg_reg_wdata(dbg_reg_wdata),
		.dbg_reg_rdata(dbg_reg_rdata),
		.dbg_mem_we(dbg_mem_we),
		.dbg_mem_addr(dbg_mem_addr),
		.dbg_mem_wdata(dbg_mem_wdata),
		.dbg_mem_rdata(dbg_mem_rdata)
	);

	always #4 clk = ~clk;

	// --------------------
	// watchdog and transaction count
	// --------------------
	always @(posedge clk) begin
		if (uut.mem_start)
			txn_count <= txn_count + 1;
		if (cmd_req || cmd_ack)
			busy_cycles <= busy_cycles + 1; // only handshake cycles count.
		if (limit > 0 && busy_cycles >= limit) begin
			$display("timeout: commands took more than %0d handshake cycles", limit);
			$display("test failed");
			$finish;
		end
	end

	function automatic word xorshift(input word x);
		word y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic check_word(input string what, input word got, input word exp);
		if (got !== exp) begin
			word_errors++;
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_reg_list(input string what, input reg_list got, input reg_list exp);
		if (got !== exp) begin
			list_errors++;
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic protocol_error(input string msg);
		proto_errors++;
		$display("handshake problem at %0t: %s", $time, msg);
	endtask

	task automatic write_reg(input reg_num r, input word d);
		@(posedge clk);
		dbg_reg_we <= 1'b1;
		dbg_reg <= r;
		dbg_reg_wdata <= d;
		@(posedge clk);
		dbg_reg_we <= 1'b0;
	endtask

	task automatic write_mem(input ptr a, input word d);
		@(posedge clk);
		dbg_mem_we <= 1'b1;
		dbg_mem_addr <= a;
		dbg_mem_wdata <= d;
		@(posedge clk);
		dbg_mem_we <= 1'b0;
	endtask

	task automatic read_reg(input reg_num r, output word d);
		@(posedge clk);
		dbg_reg <= r;
		@(negedge clk);
		d = dbg_reg_rdata;
	endtask

	task automatic read_mem(input ptr a, output word d);
		@(posedge clk);
		dbg_mem_addr <= a;
		@(negedge clk);
		d = dbg_mem_rdata;
	endtask

	// reference model of one command on exp_reg and exp_mem.
	task automatic apply_model(input ldst_op op, input reg_num base, input reg_list regs,
		input logic pre, input logic inc, input logic wb);
		word b, addr;
		int  n, r;
		b = exp_reg[base];
		n = 0;
		addr = !pre ? b : inc ? b + 4 : b - 4;
		for (int k = 0; k < NUM_REGS; k++) begin
			r = inc ? k : NUM_REGS - 1 - k; // decrement walks from the top.
			if (regs[r]) begin
				if (op == op_load)
					exp_reg[r] = exp_mem[addr[MEM_IDX_BITS+1:2]];
				else
					exp_mem[addr[MEM_IDX_BITS+1:2]] = exp_reg[r];
				addr = inc ? addr + 4 : addr - 4;
				n++;
			end
		end
		if (wb && n > 0)
			exp_reg[base] = inc ? b + word'(4 * n) : b - word'(4 * n);
	endtask

	task automatic run_command(input ldst_op op, input reg_num base, input reg_list regs,
		input logic pre, input logic inc, input logic wb, input word exp_count);
		int start_txn;
		start_txn = txn_count;
		@(posedge clk);
		cmd_req <= 1'b1;
		cmd_op <= op;
		cmd_base <= base;
		cmd_regs <= regs;
		cmd_pre <= pre;
		cmd_increment <= inc;
		cmd_writeback <= wb;
		@(negedge clk);
		if (cmd_ack)
			protocol_error("cmd_ack was already high when cmd_req rose");
		while (!cmd_ack)
			@(negedge clk);
		check_word("transfer count", word'(txn_count - start_txn), exp_count);
		repeat (2) begin
			@(negedge clk);
			if (!cmd_ack)
				protocol_error("cmd_ack fell while cmd_req was still high");
		end
		@(posedge clk);
		cmd_req <= 1'b0;
		@(negedge clk);
		if (!cmd_ack)
			protocol_error("cmd_ack fell in the same cycle as cmd_req");
		@(negedge clk);
		if (cmd_ack)
			protocol_error("cmd_ack did not fall one cycle after cmd_req");
	endtask

	task automatic check_state(input reg_num base, input word exp_base);
		word     got;
		reg_list changed, exp_changed;
		changed = '0;
		exp_changed = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			read_reg(reg_num'(i), got);
			check_word($sformatf("register %0d", i), got, exp_reg[i]);
			changed[i] = got != init_reg[i];
			exp_changed[i] = exp_reg[i] != init_reg[i];
			if (reg_num'(i) == base)
				check_word("final base", got, exp_base);
		end
		check_reg_list("changed registers", changed, exp_changed);
		for (int i = 0; i < MEM_WORDS; i++) begin
			read_mem(ptr'(i), got);
			check_word($sformatf("memory word %0d", i), got, exp_mem[i]);
		end
	endtask

	initial begin
		word rng, v;
		int  k;
		clk = 1'b0;
		rst_n = 1'b0;
		cmd_req = 1'b0;
		cmd_op = op_load;
		cmd_base = '0;
		cmd_regs = '0;
		cmd_pre = 1'b0;
		cmd_increment = 1'b0;
		cmd_writeback = 1'b0;
		dbg_reg_we = 1'b0;
		dbg_reg = '0;
		dbg_reg_wdata = '0;
		dbg_mem_we = 1'b0;
		dbg_mem_addr = '0;
		dbg_mem_wdata = '0;
		limit = 0;

		for (int i = 0; i < MAX_CASES * FIELDS; i++)
			case_data[i] = '1;
		$readmemh("tb/ldst_cases.txt", case_data);
		num_cases = 0;
		while (num_cases < MAX_CASES && case_data[num_cases * FIELDS + 1] != '1)
			num_cases++;
		limit = num_cases * CASE_CYCLES;

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (cmd_ack)
			protocol_error("cmd_ack is high after reset");
		for (int i = 0; i < NUM_REGS; i++) begin
			read_reg(reg_num'(i), v);
			check_word($sformatf("register %0d after reset", i), v, '0);
			exp_reg[i] = '0;
		end

		// memory image, loaded once.
		rng = 32'h7f6ec9a0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			rng = xorshift(rng);
			exp_mem[i] = rng;
			write_mem(ptr'(i), rng);
		end

		for (int c = 0; c < num_cases; c++) begin
			k = c * FIELDS;
			if (case_data[k + 7] != '0) begin // seed 0 keeps registers.
				rng = 32'h7f6ec9a0 ^ case_data[k + 7];
				for (int i = 0; i < NUM_REGS; i++) begin
					rng = xorshift(rng);
					exp_reg[i] = rng;
				end
				exp_reg[case_data[k + 2][3:0]] = case_data[k];
				for (int i = 0; i < NUM_REGS; i++)
					write_reg(reg_num'(i), exp_reg[i]);
			end
			init_reg = exp_reg;
			apply_model(ldst_op'(case_data[k + 1][0]), case_data[k + 2][3:0],
				case_data[k + 3][15:0], case_data[k + 4][0], case_data[k + 5][0],
				case_data[k + 6][0]);
			run_command(ldst_op'(case_data[k + 1][0]), case_data[k + 2][3:0],
				case_data[k + 3][15:0], case_data[k + 4][0], case_data[k + 5][0],
				case_data[k + 6][0], case_data[k + 9]);
			check_state(case_data[k + 2][3:0], case_data[k + 8]);
		end

		$display("errors: word %0d, register list %0d, handshake %0d",
			word_errors, list_errors, proto_errors);
		if (word_errors + list_errors + proto_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
